// File: build.f
memCtrlPkg.sv
reqArbiter.sv
byteSequencer.sv
wordAssembler.sv
memCtrlTop.sv
tbClock.sv
tbRam.sv
memCtrlProperties.sv
memCtrlTb.sv

// File: byteSequencer.sv
`timescale 1ns/10ps

module byteSequencer (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_rdy,

    input  logic                            i_startStb,
    input  logic                            i_startSrc,
    input  logic                            i_startWrite,
    input  logic [memCtrlPkg::LEN_W-1:0]    i_startLen,
    input  logic [memCtrlPkg::ADDR_W-1:0]   i_startAddr,
    input  logic [memCtrlPkg::WORD_W-1:0]   i_startWdata,

    output logic                            o_busy,

    output logic [memCtrlPkg::ADDR_W-1:0]   o_ramAddr,
    output logic                            o_ramWe,
    output logic [memCtrlPkg::BYTE_W-1:0]   o_ramWdata,

    output logic                            o_readStb,
    output logic                            o_readSrc,
    output logic [memCtrlPkg::LEN_W-1:0]    o_readIdx,
    output logic                            o_readLast,
    output logic                            o_writeDone
);

    logic                            active;
    logic [memCtrlPkg::LEN_W-1:0]    cnt;

    logic [memCtrlPkg::ADDR_W-1:0]   baseAddr;
    logic [memCtrlPkg::WORD_W-1:0]   wordReg;
    logic [memCtrlPkg::LEN_W-1:0]    lenReg;
    logic                            writeReg;
    logic                            srcReg;
    logic [memCtrlPkg::ADDR_W-1:0]   prevAddr;

    logic                            curValid;
    logic                            curWrite;
    logic                            curSrc;
    logic                            curLast;
    logic                            writing;
    logic [memCtrlPkg::LEN_W-1:0]    curLen;
    logic [memCtrlPkg::ADDR_W-1:0]   curBase;
    logic [memCtrlPkg::ADDR_W-1:0]   curAddr;
    logic [memCtrlPkg::ADDR_W-1:0]   cntExt;
    logic [memCtrlPkg::WORD_W-1:0]   curWord;

    // byte 0 goes out in the start cycle, straight from the arbiter
    assign curValid = active || i_startStb;
    assign curWrite = active ? writeReg : i_startWrite;
    assign curSrc = active ? srcReg : i_startSrc;
    assign curLen = active ? lenReg : i_startLen;
    assign curBase = active ? baseAddr : i_startAddr;
    assign curWord = active ? wordReg : i_startWdata;

    // cnt rests at zero while idle
    assign cntExt = {{(memCtrlPkg::ADDR_W - memCtrlPkg::LEN_W){1'b0}}, cnt};
    assign curAddr = curBase + cntExt;
    assign curLast = (cnt == curLen - 1'b1);
    assign writing = curValid && (curWrite == memCtrlPkg::RAM_WRITE);

    // in a stall keep the last address, so the pending read byte comes back again
    assign o_ramAddr = i_rdy ? curAddr : prevAddr;
    assign o_ramWe = (i_rdy && writing) ? memCtrlPkg::RAM_WRITE : memCtrlPkg::RAM_READ;
    assign o_ramWdata = curWord[memCtrlPkg::BYTE_W*cnt +: memCtrlPkg::BYTE_W];
    assign o_writeDone = i_rdy && writing && curLast;
    assign o_busy = active;

    always_ff @(posedge clk) begin
        if (rst) begin
            active <= 1'b0;
            cnt <= '0;
            o_readStb <= 1'b0;
        end else if (i_rdy) begin
            o_readStb <= curValid && !writing;
            if (curValid) begin
                active <= !curLast;
                cnt <= curLast ? '0 : cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_rdy) begin
            prevAddr <= curAddr;
            // read data arrives one cycle later
            o_readSrc <= curSrc;
            o_readIdx <= cnt;
            o_readLast <= curLast;
            if (i_startStb) begin
                baseAddr <= i_startAddr;
                wordReg <= i_startWdata;
                lenReg <= i_startLen;
                writeReg <= i_startWrite;
                srcReg <= i_startSrc;
            end
        end
    end

endmodule

// File: memCtrlPkg.sv
package memCtrlPkg;

    // RAM address, 128 KiB
    localparam int ADDR_W = 17;

    // RAM data width
    localparam int BYTE_W = 8;

    // width of an instruction and of a data word
    localparam int WORD_W = 32;

    // byte count of a request, values 1, 2 or 4
    localparam int LEN_W = 3;

    // a fetch always reads a whole instruction
    localparam logic [LEN_W-1:0] INST_LEN = 3'd4;

    // RAM write enable levels
    localparam logic RAM_READ = 1'b0;
    localparam logic RAM_WRITE = 1'b1;

    // which client a transaction belongs to
    localparam logic SRC_FETCH = 1'b0;
    localparam logic SRC_DATA = 1'b1;

endpackage

// File: memCtrlProperties.sv
`timescale 1ns/10ps

module memCtrlProperties (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_rdy,
    input  logic                            i_dataReq,
    input  logic [memCtrlPkg::LEN_W-1:0]    i_dataLen,
    input  logic                            i_fetchDone,
    input  logic                            i_dataDone,
    input  logic                            i_ramWe
);

    int failCount = 0;

    fetchDonePulse: assert property (@(posedge clk) disable iff (rst)
        i_fetchDone |=> !i_fetchDone)
        else begin
            failCount++;
            $error("fetch done strobe lasted more than one cycle");
        end

    dataDonePulse: assert property (@(posedge clk) disable iff (rst)
        i_dataDone |=> !i_dataDone)
        else begin
            failCount++;
            $error("data done strobe lasted more than one cycle");
        end

    // no writes while frozen
    noWriteInStall: assert property (@(posedge clk) disable iff (rst)
        !i_rdy |-> (i_ramWe == memCtrlPkg::RAM_READ))
        else begin
            failCount++;
            $error("RAM write enable high while rdy is low");
        end

    legalDataLen: assert property (@(posedge clk) disable iff (rst)
        i_dataReq |-> (i_dataLen inside {3'd1, 3'd2, 3'd4}))
        else begin
            failCount++;
            $error("data request with a length other than 1, 2 or 4");
        end

    quietInReset: assert property (@(posedge clk)
        rst |-> (!i_fetchDone && !i_dataDone))
        else begin
            failCount++;
            $error("done strobe during reset");
        end

endmodule

bind memCtrlTop memCtrlProperties u_props (
    .clk         (clk),
    .rst         (rst),
    .i_rdy       (i_rdy),
    .i_dataReq   (i_dataReq),
    .i_dataLen   (i_dataLen),
    .i_fetchDone (o_fetchDone),
    .i_dataDone  (o_dataDone),
    .i_ramWe     (o_ramWe)
);

// File: memCtrlTb.sv
`timescale 1ns/10ps

module memCtrlTb;

    logic clk;
    logic rst;
    logic rdy = 1'b0;
    logic fetchReq;
    logic [memCtrlPkg::ADDR_W-1:0] fetchAddr;
    logic fetchDone;
    logic [memCtrlPkg::WORD_W-1:0] fetchInst;
    logic dataReq;
    logic dataWrite;
    logic [memCtrlPkg::LEN_W-1:0] dataLen;
    logic [memCtrlPkg::ADDR_W-1:0] dataAddr;
    logic [memCtrlPkg::WORD_W-1:0] dataWdata;
    logic dataDone;
    logic [memCtrlPkg::WORD_W-1:0] dataRdata;
    logic [memCtrlPkg::BYTE_W-1:0] ramRdata;
    logic [memCtrlPkg::ADDR_W-1:0] ramAddr;
    logic ramWe;
    logic [memCtrlPkg::BYTE_W-1:0] ramWdata;

    integer seed;
    logic stallMode;

    // stimulus table, one entry per row in each queue
    string rowName[$];
    string rowKind[$];
    int rowAddr[$];
    int rowLen[$];
    logic [memCtrlPkg::WORD_W-1:0] rowWdata[$];
    logic [memCtrlPkg::WORD_W-1:0] rowExpData[$];
    logic [memCtrlPkg::WORD_W-1:0] rowExpFetch[$];
    // bytes changed by earlier store rows
    logic [memCtrlPkg::BYTE_W-1:0] written[int];

    tbClock u_clock (.o_clk(clk), .o_rst(rst));

    memCtrlTop u_dut (
        .clk(clk), .rst(rst), .i_rdy(rdy),
        .i_fetchReq(fetchReq), .i_fetchAddr(fetchAddr),
        .o_fetchDone(fetchDone), .o_fetchInst(fetchInst),
        .i_dataReq(dataReq), .i_dataWrite(dataWrite), .i_dataLen(dataLen),
        .i_dataAddr(dataAddr), .i_dataWdata(dataWdata),
        .o_dataDone(dataDone), .o_dataRdata(dataRdata),
        .i_ramRdata(ramRdata), .o_ramAddr(ramAddr), .o_ramWe(ramWe), .o_ramWdata(ramWdata)
    );

    tbRam u_ram (
        .clk(clk), .i_addr(ramAddr), .i_we(ramWe),
        .i_wdata(ramWdata), .o_rdata(ramRdata)
    );

    // stalls come in at random, about one cycle in four
    always @(posedge clk) begin
        if (stallMode) begin
            rdy <= ($random(seed) & 3) != 0;
        end else begin
            rdy <= 1'b1;
        end
    end

    task automatic abortRun(input string why);
        $display("Something failed");
        $fatal(1, "%s", why);
    endtask

    task automatic checkWord(input string name, input logic [memCtrlPkg::WORD_W-1:0] expected,
                             input logic [memCtrlPkg::WORD_W-1:0] actual);
        if (actual !== expected) begin
            $display("Fail %s expected %h actual %h", name, expected, actual);
            abortRun({"wrong word in ", name});
        end
    endtask

    task automatic checkBit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            $display("Fail %s expected %b actual %b", name, expected, actual);
            abortRun({"wrong bit in ", name});
        end
    endtask

    function automatic logic [memCtrlPkg::BYTE_W-1:0] initByte(
        input logic [memCtrlPkg::ADDR_W-1:0] a
    );
        return a[7:0] ^ a[15:8] ^ {7'b0, a[16]} ^ 8'h5a;
    endfunction

    // four preload bytes from addr upward
    function automatic logic [memCtrlPkg::WORD_W-1:0] preloadWord(input int addr);
        logic [memCtrlPkg::WORD_W-1:0] word;
        for (int k = 0; k < 4; k++) begin
            word[8*k +: 8] = initByte(addr + k);
        end
        return word;
    endfunction

    // little-endian, zero above the length
    function automatic logic [memCtrlPkg::WORD_W-1:0] expectRead(input int addr, input int len);
        logic [memCtrlPkg::WORD_W-1:0] word;
        word = '0;
        for (int k = 0; k < len; k++) begin
            word[8*k +: 8] = written.exists(addr + k) ? written[addr + k] : initByte(addr + k);
        end
        return word;
    endfunction

    task automatic addRow(input string name, input string kind, input int addr, input int len,
                          input logic [memCtrlPkg::WORD_W-1:0] wdata);
        logic [memCtrlPkg::WORD_W-1:0] expData;
        logic [memCtrlPkg::WORD_W-1:0] expFetch;
        expData = '0;
        expFetch = '0;
        if (kind == "store") begin
            for (int k = 0; k < len; k++) begin
                written[addr + k] = wdata[8*k +: 8];
            end
        end
        if (kind == "load" || kind == "both") begin
            expData = expectRead(addr, len);
        end
        if (kind == "fetch" || kind == "both") begin
            expFetch = expectRead(addr, memCtrlPkg::INST_LEN);
        end
        rowName.push_back(name);
        rowKind.push_back(kind);
        rowAddr.push_back(addr);
        rowLen.push_back(len);
        rowWdata.push_back(wdata);
        rowExpData.push_back(expData);
        rowExpFetch.push_back(expFetch);
    endtask

    task automatic waitDone(input string name, input logic wantFetch, input logic wantData,
                            input logic isWrite, input logic [memCtrlPkg::WORD_W-1:0] expFetch,
                            input logic [memCtrlPkg::WORD_W-1:0] expData);
        int cycles;
        int fetchAt;
        int dataAt;
        logic gotFetch;
        logic gotData;
        cycles = 0;
        fetchAt = 0;
        dataAt = 0;
        gotFetch = !wantFetch;
        gotData = !wantData;
        while (!(gotFetch && gotData)) begin
            @(negedge clk);
            cycles++;
            if (cycles > 200) begin
                abortRun({"no done strobe within 200 cycles in ", name});
            end
            if (fetchDone) begin
                if (gotFetch) begin
                    abortRun({"unexpected fetch done in ", name});
                end
                gotFetch = 1'b1;
                fetchAt = cycles;
                checkWord({name, " inst"}, expFetch, fetchInst);
            end
            if (dataDone) begin
                if (gotData) begin
                    abortRun({"unexpected data done in ", name});
                end
                gotData = 1'b1;
                dataAt = cycles;
                if (!isWrite) begin
                    checkWord({name, " rdata"}, expData, dataRdata);
                end
            end
        end
        // data wins the arbitration
        if (wantFetch && wantData) begin
            checkBit({name, " order"}, 1'b1, dataAt <= fetchAt);
        end
    endtask

    task automatic runTable(input string suffix);
        logic isFetch;
        logic isData;
        logic isWrite;
        for (int r = 0; r < rowName.size(); r++) begin
            isFetch = rowKind[r] == "fetch" || rowKind[r] == "both";
            isData = rowKind[r] != "fetch";
            isWrite = rowKind[r] == "store";
            @(posedge clk);
            fetchReq <= isFetch;
            fetchAddr <= rowAddr[r];
            dataReq <= isData;
            dataWrite <= isWrite;
            dataLen <= rowLen[r];
            dataAddr <= rowAddr[r];
            dataWdata <= rowWdata[r];
            @(posedge clk);
            fetchReq <= 1'b0;
            dataReq <= 1'b0;
            waitDone({rowName[r], suffix}, isFetch, isData, isWrite, rowExpFetch[r], rowExpData[r]);
        end
    endtask

    initial begin
        int cycles;
        fetchReq = 1'b0;
        fetchAddr = '0;
        dataReq = 1'b0;
        dataWrite = 1'b0;
        dataLen = memCtrlPkg::INST_LEN;
        dataAddr = '0;
        dataWdata = '0;
        seed = 32'h51da;
        stallMode = 1'b0;

        addRow("fetch_0", "fetch", 'h00000, 4, '0);
        addRow("fetch_123", "fetch", 'h00123, 4, '0);
        addRow("fetch_a5a1", "fetch", 'h0a5a1, 4, '0);
        addRow("fetch_top", "fetch", 'h1fffc, 4, '0);
        addRow("load_len1", "load", 'h00301, 1, '0);
        addRow("load_len2", "load", 'h00402, 2, '0);
        addRow("load_len4", "load", 'h10505, 4, '0);
        addRow("load_cross", "load", 'h0fffe, 4, '0);
        addRow("store_len1", "store", 'h02000, 1, 32'hdeadbe11);
        addRow("check_len1", "load", 'h02000, 4, '0);
        addRow("store_len2", "store", 'h02011, 2, 32'hcafe1234);
        addRow("check_len2", "load", 'h02011, 4, '0);
        addRow("store_len4", "store", 'h02022, 4, 32'h89abcdef);
        addRow("check_len4", "load", 'h02022, 4, '0);
        addRow("both_len4", "both", 'h00700, 4, '0);
        addRow("both_len1", "both", 'h00811, 1, '0);
        addRow("both_len2", "both", 'h01234, 2, '0);
        // put the preload back, so each pass starts from the same contents
        addRow("restore_len1", "store", 'h02000, 1, preloadWord('h02000));
        addRow("restore_len2", "store", 'h02011, 2, preloadWord('h02011));
        addRow("restore_len4", "store", 'h02022, 4, preloadWord('h02022));

        cycles = 0;
        @(posedge clk);
        while (rst) begin
            @(posedge clk);
            cycles++;
            if (cycles > 10) begin
                abortRun("reset was never released");
            end
        end
        @(posedge clk);

        // idle controller after reset
        for (int c = 0; c < 20; c++) begin
            @(negedge clk);
            checkBit("idle_fetch_done", 1'b0, fetchDone);
            checkBit("idle_data_done", 1'b0, dataDone);
            checkBit("idle_ram_we", memCtrlPkg::RAM_READ, ramWe);
        end

        runTable("");
        stallMode = 1'b1;
        runTable("_stall");
        stallMode = 1'b0;
        repeat (4) @(posedge clk);

        if (u_dut.u_props.failCount != 0) begin
            abortRun("assertions reported errors");
        end else begin
            $display("Everything OK");
            $finish;
        end
    end

endmodule

// File: memCtrlTop.sv
`timescale 1ns/10ps

module memCtrlTop (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_rdy,

    // instruction fetch
    input  logic                            i_fetchReq,
    input  logic [memCtrlPkg::ADDR_W-1:0]   i_fetchAddr,
    output logic                            o_fetchDone,
    output logic [memCtrlPkg::WORD_W-1:0]   o_fetchInst,

    // data load and store
    input  logic                            i_dataReq,
    input  logic                            i_dataWrite,
    input  logic [memCtrlPkg::LEN_W-1:0]    i_dataLen,
    input  logic [memCtrlPkg::ADDR_W-1:0]   i_dataAddr,
    input  logic [memCtrlPkg::WORD_W-1:0]   i_dataWdata,
    output logic                            o_dataDone,
    output logic [memCtrlPkg::WORD_W-1:0]   o_dataRdata,

    // byte RAM
    input  logic [memCtrlPkg::BYTE_W-1:0]   i_ramRdata,
    output logic [memCtrlPkg::ADDR_W-1:0]   o_ramAddr,
    output logic                            o_ramWe,
    output logic [memCtrlPkg::BYTE_W-1:0]   o_ramWdata
);

    logic                            startStb;
    logic                            startSrc;
    logic                            startWrite;
    logic [memCtrlPkg::LEN_W-1:0]    startLen;
    logic [memCtrlPkg::ADDR_W-1:0]   startAddr;
    logic [memCtrlPkg::WORD_W-1:0]   startWdata;
    logic                            seqBusy;

    logic                            readStb;
    logic                            readSrc;
    logic [memCtrlPkg::LEN_W-1:0]    readIdx;
    logic                            readLast;

    logic                            writeDone;
    logic                            loadDone;

    reqArbiter u_arbiter (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_fetchReq   (i_fetchReq),
        .i_fetchAddr  (i_fetchAddr),
        .i_dataReq    (i_dataReq),
        .i_dataWrite  (i_dataWrite),
        .i_dataLen    (i_dataLen),
        .i_dataAddr   (i_dataAddr),
        .i_dataWdata  (i_dataWdata),
        .i_seqBusy    (seqBusy),
        .o_startStb   (startStb),
        .o_startSrc   (startSrc),
        .o_startWrite (startWrite),
        .o_startLen   (startLen),
        .o_startAddr  (startAddr),
        .o_startWdata (startWdata)
    );

    byteSequencer u_sequencer (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_startStb   (startStb),
        .i_startSrc   (startSrc),
        .i_startWrite (startWrite),
        .i_startLen   (startLen),
        .i_startAddr  (startAddr),
        .i_startWdata (startWdata),
        .o_busy       (seqBusy),
        .o_ramAddr    (o_ramAddr),
        .o_ramWe      (o_ramWe),
        .o_ramWdata   (o_ramWdata),
        .o_readStb    (readStb),
        .o_readSrc    (readSrc),
        .o_readIdx    (readIdx),
        .o_readLast   (readLast),
        .o_writeDone  (writeDone)
    );

    wordAssembler u_assembler (
        .clk          (clk),
        .rst          (rst),
        .i_rdy        (i_rdy),
        .i_readStb    (readStb),
        .i_readSrc    (readSrc),
        .i_readIdx    (readIdx),
        .i_readLast   (readLast),
        .i_ramRdata   (i_ramRdata),
        .o_fetchDone  (o_fetchDone),
        .o_fetchInst  (o_fetchInst),
        .o_dataDone   (loadDone),
        .o_dataRdata  (o_dataRdata)
    );

    // stores finish on the last write, loads on the last returned byte
    assign o_dataDone = loadDone | writeDone;

endmodule

// File: reqArbiter.sv
`timescale 1ns/10ps

module reqArbiter (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_rdy,

    input  logic                            i_fetchReq,
    input  logic [memCtrlPkg::ADDR_W-1:0]   i_fetchAddr,

    input  logic                            i_dataReq,
    input  logic                            i_dataWrite,
    input  logic [memCtrlPkg::LEN_W-1:0]    i_dataLen,
    input  logic [memCtrlPkg::ADDR_W-1:0]   i_dataAddr,
    input  logic [memCtrlPkg::WORD_W-1:0]   i_dataWdata,

    input  logic                            i_seqBusy,

    output logic                            o_startStb,
    output logic                            o_startSrc,
    output logic                            o_startWrite,
    output logic [memCtrlPkg::LEN_W-1:0]    o_startLen,
    output logic [memCtrlPkg::ADDR_W-1:0]   o_startAddr,
    output logic [memCtrlPkg::WORD_W-1:0]   o_startWdata
);

    logic                            fetchPend;
    logic [memCtrlPkg::ADDR_W-1:0]   fetchAddr;

    logic                            dataPend;
    logic                            dataWe;
    logic [memCtrlPkg::LEN_W-1:0]    dataLen;
    logic [memCtrlPkg::ADDR_W-1:0]   dataAddr;
    logic [memCtrlPkg::WORD_W-1:0]   dataWdata;

    logic                            takeFetch;
    logic                            takeData;

    // one transaction at a time, data before fetch
    assign o_startStb = i_rdy && !i_seqBusy && (dataPend || fetchPend);
    assign takeData = o_startStb && dataPend;
    assign takeFetch = o_startStb && !dataPend;

    assign o_startSrc = dataPend ? memCtrlPkg::SRC_DATA : memCtrlPkg::SRC_FETCH;
    assign o_startWrite = dataPend ? dataWe : memCtrlPkg::RAM_READ;
    assign o_startLen = dataPend ? dataLen : memCtrlPkg::INST_LEN;
    assign o_startAddr = dataPend ? dataAddr : fetchAddr;
    assign o_startWdata = dataWdata;

    // strobes are taken even in a stall
    always_ff @(posedge clk) begin
        if (rst) begin
            fetchPend <= 1'b0;
            dataPend <= 1'b0;
        end else begin
            if (takeFetch) begin
                fetchPend <= 1'b0;
            end
            if (i_fetchReq) begin
                fetchPend <= 1'b1;
            end
            if (takeData) begin
                dataPend <= 1'b0;
            end
            if (i_dataReq) begin
                dataPend <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_fetchReq) begin
            fetchAddr <= i_fetchAddr;
        end
        if (i_dataReq) begin
            dataWe <= i_dataWrite ? memCtrlPkg::RAM_WRITE : memCtrlPkg::RAM_READ;
            dataLen <= i_dataLen;
            dataAddr <= i_dataAddr;
            dataWdata <= i_dataWdata;
        end
    end

endmodule

// File: tbClock.sv
`timescale 1ns/10ps

module tbClock (
    output logic o_clk,
    output logic o_rst
);

    // 40 ns period
    initial begin
        o_clk = 1'b0;
        forever #20 o_clk = ~o_clk;
    end

    // reset held for four rising edges
    initial begin
        o_rst = 1'b1;
        repeat (4) @(posedge o_clk);
        o_rst <= 1'b0;
    end

endmodule

// File: tbRam.sv
`timescale 1ns/10ps

module tbRam (
    input  logic                            clk,
    input  logic [memCtrlPkg::ADDR_W-1:0]   i_addr,
    input  logic                            i_we,
    input  logic [memCtrlPkg::BYTE_W-1:0]   i_wdata,
    output logic [memCtrlPkg::BYTE_W-1:0]   o_rdata
);

    logic [memCtrlPkg::BYTE_W-1:0] mem [0:(1 << memCtrlPkg::ADDR_W)-1];

    // every address bit takes part in the fill byte
    initial begin
        logic [memCtrlPkg::ADDR_W-1:0] a;
        for (int i = 0; i < (1 << memCtrlPkg::ADDR_W); i++) begin
            a = i;
            mem[i] = a[7:0] ^ a[15:8] ^ {7'b0, a[16]} ^ 8'h5a;
        end
    end

    // read data is registered, old contents on a write
    always @(posedge clk) begin
        if (i_we == memCtrlPkg::RAM_WRITE) begin
            mem[i_addr] <= i_wdata;
        end
        o_rdata <= mem[i_addr];
    end

endmodule

// File: wordAssembler.sv
`timescale 1ns/10ps

module wordAssembler (
    input  logic                            clk,
    input  logic                            rst,
    input  logic                            i_rdy,

    input  logic                            i_readStb,
    input  logic                            i_readSrc,
    input  logic [memCtrlPkg::LEN_W-1:0]    i_readIdx,
    input  logic                            i_readLast,
    input  logic [memCtrlPkg::BYTE_W-1:0]   i_ramRdata,

    output logic                            o_fetchDone,
    output logic [memCtrlPkg::WORD_W-1:0]   o_fetchInst,
    output logic                            o_dataDone,
    output logic [memCtrlPkg::WORD_W-1:0]   o_dataRdata
);

    logic [memCtrlPkg::WORD_W-1:0]   bufWord;
    logic [memCtrlPkg::WORD_W-1:0]   assembled;
    logic                            readEnd;

    // lanes below the arriving one come from the buffer, lanes above are zero
    always_comb begin
        for (int lane = 0; lane < memCtrlPkg::WORD_W / memCtrlPkg::BYTE_W; lane++) begin
            if (lane == i_readIdx) begin
                assembled[lane*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] = i_ramRdata;
            end else if (lane < i_readIdx) begin
                assembled[lane*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] =
                    bufWord[lane*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W];
            end else begin
                assembled[lane*memCtrlPkg::BYTE_W +: memCtrlPkg::BYTE_W] = '0;
            end
        end
    end

    assign readEnd = i_rdy && i_readStb && i_readLast;
    assign o_fetchDone = readEnd && (i_readSrc == memCtrlPkg::SRC_FETCH);
    assign o_dataDone = readEnd && (i_readSrc == memCtrlPkg::SRC_DATA);
    assign o_fetchInst = assembled;
    assign o_dataRdata = assembled;

    // lanes start empty
    always_ff @(posedge clk) begin
        if (rst) begin
            bufWord <= '0;
        end else if (i_rdy && i_readStb) begin
            bufWord[memCtrlPkg::BYTE_W*i_readIdx +: memCtrlPkg::BYTE_W] <= i_ramRdata;
        end
    end

endmodule
